/* test/proc_cases.txt */
# test <name> <cycle limit> | i <addr> <instr hex> | d <addr> <data hex>
# e <port> <expected data hex>, instr is opcode in bits 12:8 and operand in 7:0
test mem_arith 40
i 00 100
i 01 B00
i 02 501
i 03 B01
i 04 702
i 05 B02
i 06 901
i 07 B03
i 08 F08
d 00 1234
d 01 0F0F
d 02 00FF
e 0 1234
e 1 2143
e 2 0043
e 3 0F4C
test data_stack 50
i 00 100
i 01 300
i 02 101
i 03 300
i 04 102
i 05 300
i 06 103
i 07 600
i 08 B00
i 09 A00
i 0A B01
i 0B 400
i 0C B02
i 0D 300
i 0E 102
i 0F 800
i 10 B03
i 11 F11
d 00 0003
d 01 0005
d 02 0006
d 03 00FF
e 0 0105
e 1 0100
e 2 0003
e 3 0002
test jumps 40
i 00 F03
i 01 B03
i 02 B03
i 03 101
i 04 1008
i 05 B00
i 06 100
i 07 100A
i 08 B03
i 09 B03
i 0A B01
i 0B F0B
d 00 0000
d 01 0007
e 0 0007
e 1 0000
test nested_calls 50
i 00 100
i 01 1106
i 02 B00
i 03 F03
i 06 101
i 07 B01
i 08 110C
i 09 502
i 0A B02
i 0B 1200
i 0C 103
i 0D B03
i 0E 1200
d 00 0001
d 01 0002
d 02 0004
d 03 0008
e 1 0002
e 3 0008
e 2 000C
e 0 000C
test set_round_trip 40
i 00 100
i 01 205
i 02 101
i 03 000
i 04 105
i 05 B02
i 06 501
i 07 B00
i 08 F08
d 00 00AB
d 01 1100
e 2 00AB
e 0 11AB
test jiz_after_xor 40
i 00 100
i 01 900
i 02 1005
i 03 B03
i 04 B03
i 05 B01
i 06 500
i 07 1009
i 08 B02
i 09 F09
d 00 5555
e 1 0000
e 2 5555

/* compile.f */
+incdir+hdl
hdl/proc_pkg.sv
hdl/lifo_stack.sv
hdl/alu.sv
hdl/instr_fetch.sv
hdl/instr_decoder.sv
hdl/data_path.sv
hdl/proc_top.sv
test/proc_properties.sv
test/proc_checker.sv
test/tb_proc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module tb_proc -o sim_tb_proc

./obj_dir/sim_tb_proc | tee sim.log

if grep -q "Test completed successfully" sim.log; then
	echo "simulation passed"
else
	echo "simulation did not pass"
	exit 1
fi

/* test/tb_proc.sv */
// Testbench for proc_top, programs and expected outputs come from test/proc_cases.txt
// At most 8 tests with 16 expected outputs each, memories are 256 words deep
// Inputs change on the falling clock edge, memory models read on the rising edge
`timescale 1ns/100ps

module tb_proc
	import proc_pkg::*;
();

	localparam int MAX_TESTS = 8;
	localparam int MAX_EXP   = 16;
	localparam int MEM_WORDS = 256;

	logic        clk;
	logic        rst;
	instr_word_t instr;
	iaddr_t      instr_addr;
	daddr_t      mem_addr_rd;
	data_word_t  mem_data_rd;
	logic        mem_wr;
	daddr_t      mem_addr_wr;
	data_word_t  mem_data_wr;
	logic        out_en;
	io_addr_t    addr_out;
	data_word_t  out_data;

	instr_word_t imem [MEM_WORDS];
	data_word_t  dmem [MEM_WORDS];

	// Images of all tests, filled once from the cases file
	instr_word_t img_i [MAX_TESTS][MEM_WORDS];
	data_word_t  img_d [MAX_TESTS][MEM_WORDS];
	io_addr_t    exp_port_all [MAX_TESTS][MAX_EXP];
	data_word_t  exp_data_all [MAX_TESTS][MAX_EXP];
	int          exp_n_all [MAX_TESTS];
	int          limit [MAX_TESTS];
	string       names [MAX_TESTS];
	int          n_tests;

	io_addr_t    exp_port [MAX_EXP];
	data_word_t  exp_data [MAX_EXP];
	int          exp_n;
	int          seen;
	int          errors;
	int          fails;
	logic        loaded;
	longint      wd_cycles;

	proc_top i_proc_top (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_addr  (instr_addr),
		.mem_addr_rd (mem_addr_rd),
		.mem_data_rd (mem_data_rd),
		.mem_wr      (mem_wr),
		.mem_addr_wr (mem_addr_wr),
		.mem_data_wr (mem_data_wr),
		.out_en      (out_en),
		.addr_out    (addr_out),
		.out_data    (out_data)
	);

	proc_checker i_proc_checker (
		.clk      (clk),
		.rst      (rst),
		.out_en   (out_en),
		.addr_out (addr_out),
		.out_data (out_data),
		.exp_port (exp_port),
		.exp_data (exp_data),
		.exp_n    (exp_n),
		.seen     (seen),
		.errors   (errors)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Synchronous read, old data on a same-address write
	always @(posedge clk) begin
		instr       <= imem[instr_addr];
		mem_data_rd <= dmem[mem_addr_rd];
		if (mem_wr) begin
			dmem[mem_addr_wr] <= mem_data_wr;
		end
	end

	// ------------------------------------------------------------
	// Cases file reader
	// ------------------------------------------------------------
	task automatic load_cases();
		int    fd;
		int    code;
		int    t;
		int    a;
		int    v;
		int    lim;
		string line;
		string tag;
		string name;
		fd = $fopen("test/proc_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open test/proc_cases.txt, no tests loaded");
		end else begin
			t = -1;
			while (!$feof(fd)) begin
				line = "";
				tag  = "";
				code = $fgets(line, fd);
				code = $sscanf(line, "%s", tag);
				if (tag == "test" && n_tests < MAX_TESTS) begin
					code = $sscanf(line, "%s %s %d", tag, name, lim);
					t = n_tests;
					n_tests++;
					names[t]     = name;
					limit[t]     = lim;
					exp_n_all[t] = 0;
					for (int i = 0; i < MEM_WORDS; i++) begin
						img_i[t][i] = '0;
						img_d[t][i] = {~8'(i), 8'(i)};
					end
				end else if (t >= 0 && (tag == "i" || tag == "d" || tag == "e")) begin
					code = $sscanf(line, "%s %h %h", tag, a, v);
					if (tag == "i") begin
						img_i[t][a] = instr_word_t'(v);
					end else if (tag == "d") begin
						img_d[t][a] = data_word_t'(v);
					end else if (exp_n_all[t] < MAX_EXP) begin
						exp_port_all[t][exp_n_all[t]] = io_addr_t'(a);
						exp_data_all[t][exp_n_all[t]] = data_word_t'(v);
						exp_n_all[t]++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Reset for 10 cycles with a fresh image, then wait for all outputs
	task automatic run_test(input int t);
		int cycles;
		@(negedge clk);
		rst = 1'b1;
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] <= img_i[t][i];
			dmem[i] <= img_d[t][i];
		end
		for (int k = 0; k < MAX_EXP; k++) begin
			exp_port[k] = exp_port_all[t][k];
			exp_data[k] = exp_data_all[t][k];
		end
		exp_n = exp_n_all[t];
		repeat (10) @(negedge clk);
		rst = 1'b0;
		cycles = 0;
		while (seen < exp_n && cycles < limit[t]) begin
			@(negedge clk);
			cycles++;
		end
		// A few more cycles to catch stray outputs
		repeat (4) @(negedge clk);
		if (seen < exp_n) begin
			$display("test %s timed out after %0d cycles with %0d of %0d outputs",
				names[t], cycles, seen, exp_n);
			fails++;
		end else if (errors != 0) begin
			$display("test %s has %0d mismatches", names[t], errors);
			fails++;
		end else begin
			$display("test %s passed, %0d outputs", names[t], seen);
		end
	endtask

	// Watchdog sized from the cycle limits
	initial begin
		wait (loaded);
		#(wd_cycles * 100);
		$display("watchdog expired after %0d cycles, run stopped", wd_cycles);
		$display("Test failed");
		$finish;
	end

	initial begin
		rst         = 1'b1;
		loaded      = 1'b0;
		n_tests     = 0;
		fails       = 0;
		exp_n       = 0;
		instr       <= '0;
		mem_data_rd <= '0;
		load_cases();
		wd_cycles = 10;
		for (int t = 0; t < n_tests; t++) begin
			wd_cycles += longint'(limit[t] + 10 + 6);
		end
		loaded = 1'b1;
		for (int t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		$display("tests run %0d, passed %0d, failed %0d", n_tests, n_tests - fails, fails);
		if (fails == 0 && n_tests > 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* test/proc_checker.sv */
// Compares each output port strobe with the next expected event
// Counters clear on reset, so they hold the figures of the current test only
`timescale 1ns/100ps

module proc_checker
	import proc_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       out_en,
	input  io_addr_t   addr_out,
	input  data_word_t out_data,
	input  io_addr_t   exp_port [16],
	input  data_word_t exp_data [16],
	input  int         exp_n,
	output int         seen,
	output int         errors
);

	int bad;

	// Port outputs are registered, so the falling edge sees them settled
	always @(negedge clk or posedge rst) begin
		if (rst) begin
			seen   <= 0;
			errors <= 0;
		end else if (out_en) begin
			bad = 0;
			if (seen >= exp_n || seen >= 16) begin
				$display("%0t: unexpected output on port %0d with data %h",
					$time, addr_out, out_data);
				bad = 1;
			end else begin
				if (addr_out !== exp_port[seen]) begin
					$display("FAILED %0t addr_out: expected %0d, got %0d",
						$time, exp_port[seen], addr_out);
					bad++;
				end
				if (out_data !== exp_data[seen]) begin
					$display("FAILED %0t out_data: expected %h, got %h",
						$time, exp_data[seen], out_data);
					bad++;
				end
			end
			seen   <= seen + 1;
			errors <= errors + bad;
		end
	end

endmodule

/* test/proc_properties.sv */
// Concurrent checks on the core, bound into every proc_top
// The stack signals are taken from inside the execute stage
`timescale 1ns/100ps

module proc_properties
	import proc_pkg::*;
(
	input logic   clk,
	input logic   rst,
	input logic   out_en,
	input logic   mem_wr,
	input iaddr_t instr_addr,
	input logic   stack_push,
	input logic   stack_pop
);

	quiet_in_reset: assert property (@(posedge clk) rst |-> (!out_en && !mem_wr && instr_addr == '0))
		else $error("output strobe, store or nonzero fetch address during reset");

	single_strobe: assert property (@(posedge clk) disable iff (rst) out_en |=> !out_en)
		else $error("out_en high for two cycles in a row");

	stack_one_action: assert property (@(posedge clk) disable iff (rst) !(stack_push && stack_pop))
		else $error("data stack push and pop in the same cycle");

endmodule

bind proc_top proc_properties i_proc_properties (
	.clk        (clk),
	.rst        (rst),
	.out_en     (out_en),
	.mem_wr     (mem_wr),
	.instr_addr (instr_addr),
	.stack_push (i_data_path.stack_push),
	.stack_pop  (i_data_path.stack_pop)
);

/* hdl/proc_top.sv */
// Stack-accumulator core, three stages of fetch, decode and execute
// Instruction and data memories sit outside, both with one-cycle synchronous read
// No handshake anywhere, out_en is a single-cycle strobe
`timescale 1ns/100ps

module proc_top
	import proc_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  instr_word_t instr,
	output iaddr_t      instr_addr,
	output daddr_t      mem_addr_rd,
	input  data_word_t  mem_data_rd,
	output logic        mem_wr,
	output daddr_t      mem_addr_wr,
	output data_word_t  mem_data_wr,
	output logic        out_en,
	output io_addr_t    addr_out,
	output data_word_t  out_data
);

	opcode_e    fe_opcode;
	operand_t   fe_operand;
	logic       fe_instr_valid;
	logic       result_zero;
	exec_ctrl_t ex_ctrl;

	// ------------------------------------------------------------
	// Fetch and decode
	// ------------------------------------------------------------
	instr_fetch i_instr_fetch (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.result_zero (result_zero),
		.instr_addr  (instr_addr),
		.opcode      (fe_opcode),
		.operand     (fe_operand),
		.instr_valid (fe_instr_valid)
	);

	// Data read is issued while the instruction is decoded
	assign mem_addr_rd = daddr_t'(fe_operand);

	instr_decoder i_instr_decoder (
		.clk         (clk),
		.rst         (rst),
		.opcode      (fe_opcode),
		.operand     (fe_operand),
		.instr_valid (fe_instr_valid),
		.ctrl        (ex_ctrl)
	);

	// ------------------------------------------------------------
	// Execute
	// ------------------------------------------------------------
	data_path i_data_path (
		.clk         (clk),
		.rst         (rst),
		.ctrl        (ex_ctrl),
		.mem_data_rd (mem_data_rd),
		.result_zero (result_zero),
		.mem_wr      (mem_wr),
		.mem_addr_wr (mem_addr_wr),
		.mem_data_wr (mem_data_wr),
		.out_en      (out_en),
		.addr_out    (addr_out),
		.out_data    (out_data)
	);

endmodule

/* hdl/data_path.sv */
// Execute stage with accumulator, data stack, store and output port
// Memory data is expected in the cycle the control arrives
// A store and a load of the same address in one cycle return the old data
`timescale 1ns/100ps

`include "proc_macros.svh"

module data_path
	import proc_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  exec_ctrl_t ctrl,
	input  data_word_t mem_data_rd,
	output logic       result_zero,
	output logic       mem_wr,
	output daddr_t     mem_addr_wr,
	output data_word_t mem_data_wr,
	output logic       out_en,
	output io_addr_t   addr_out,
	output data_word_t out_data
);

	data_word_t acc;
	data_word_t stack_top;
	data_word_t alu_b;
	data_word_t alu_y;
	data_word_t result;
	logic       acc_wr;
	logic       stack_push;
	logic       stack_pop;
	logic       port_wr;

	assign acc_wr     = ctrl.valid & ctrl.acc_wr;
	assign stack_push = ctrl.valid & ctrl.push;
	assign stack_pop  = ctrl.valid & ctrl.pop;
	assign port_wr    = ctrl.valid & ctrl.out_en;

	// ------------------------------------------------------------
	// Operands and ALU
	// ------------------------------------------------------------
	assign alu_b = ctrl.use_stack ? stack_top : mem_data_rd;

	alu i_alu (
		.op (ctrl.alu_op),
		.a  (acc),
		.b  (alu_b),
		.y  (alu_y)
	);

	lifo_stack #(
		.WIDTH (`PROC_DATA_W),
		.DEPTH (`PROC_DSTACK_DEPTH)
	) i_data_stack (
		.clk  (clk),
		.rst  (rst),
		.push (stack_push),
		.pop  (stack_pop),
		.din  (acc),
		.top  (stack_top)
	);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else if (acc_wr) begin
			acc <= alu_y;
		end
	end

	// Instructions that leave acc alone report acc itself to JIZ
	assign result      = acc_wr ? alu_y : acc;
	assign result_zero = (result == '0);

	// ------------------------------------------------------------
	// Store and output port
	// ------------------------------------------------------------
	assign mem_wr      = ctrl.valid & ctrl.mem_wr;
	assign mem_addr_wr = daddr_t'(ctrl.operand);
	assign mem_data_wr = acc;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_en <= 1'b0;
		end else begin
			out_en <= port_wr;
		end
	end

	always_ff @(posedge clk) begin
		if (port_wr) begin
			addr_out <= ctrl.operand[`PROC_IO_W-1:0];
			out_data <= acc;
		end
	end

endmodule

/* hdl/instr_decoder.sv */
// Decode of the non-branch opcodes into execute-stage control
// The control is registered so it lines up with the data memory read
// Branches, NOP and unknown opcodes leave valid low
`timescale 1ns/100ps

module instr_decoder
	import proc_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  opcode_e    opcode,
	input  operand_t   operand,
	input  logic       instr_valid,
	output exec_ctrl_t ctrl
);

	exec_ctrl_t ctrl_next;

	// ALU operation shared by memory and stack forms
	function automatic alu_op_e alu_of(input opcode_e op);
		case (op)
			ADD, S_ADD: return ALU_ADD;
			AND, S_AND: return ALU_AND;
			XOR, S_XOR: return ALU_XOR;
			default:    return ALU_PASS;
		endcase
	endfunction

	always_comb begin
		ctrl_next         = '0;
		ctrl_next.alu_op  = alu_of(opcode);
		ctrl_next.operand = operand;
		if (instr_valid) begin
			case (opcode)
				// Accumulator with memory operand
				LOD, ADD, AND, XOR: begin
					ctrl_next.valid  = 1'b1;
					ctrl_next.acc_wr = 1'b1;
				end
				// Accumulator with stack top, which is consumed
				POP, S_ADD, S_AND, S_XOR: begin
					ctrl_next.valid     = 1'b1;
					ctrl_next.acc_wr    = 1'b1;
					ctrl_next.use_stack = 1'b1;
					ctrl_next.pop       = 1'b1;
				end
				SET: begin
					ctrl_next.valid  = 1'b1;
					ctrl_next.mem_wr = 1'b1;
				end
				PSH: begin
					ctrl_next.valid = 1'b1;
					ctrl_next.push  = 1'b1;
				end
				OUT: begin
					ctrl_next.valid  = 1'b1;
					ctrl_next.out_en = 1'b1;
				end
				NOP, JMP, JIZ, CAL, RET: ctrl_next.valid = 1'b0;
				default:                 ctrl_next.valid = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ctrl <= '0;
		end else begin
			ctrl <= ctrl_next;
		end
	end

endmodule

/* hdl/instr_fetch.sv */
// Program counter, branch decode and return stack
// Branches resolve in decode with no bubble, JIZ tests the instruction in execute
// Instruction memory is assumed to read with exactly one cycle of latency
`timescale 1ns/100ps

`include "proc_macros.svh"

module instr_fetch
	import proc_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  instr_word_t instr,
	input  logic        result_zero,
	output iaddr_t      instr_addr,
	output opcode_e     opcode,
	output operand_t    operand,
	output logic        instr_valid
);

	iaddr_t pc;
	iaddr_t ret_top;
	logic   take_jmp;
	logic   is_cal;
	logic   is_ret;

	// Instruction word fields
	assign opcode  = opcode_e'(instr[`PROC_INSTR_W-1:`PROC_OPR_W]);
	assign operand = instr[`PROC_OPR_W-1:0];

	// ------------------------------------------------------------
	// Branch decode
	// ------------------------------------------------------------
	always_comb begin
		take_jmp = 1'b0;
		is_cal   = 1'b0;
		is_ret   = 1'b0;
		if (instr_valid) begin
			case (opcode)
				JMP:     take_jmp = 1'b1;
				JIZ:     take_jmp = result_zero;
				CAL:     is_cal   = 1'b1;
				RET:     is_ret   = 1'b1;
				default: take_jmp = 1'b0;
			endcase
		end
	end

	// Target goes out in the decode cycle itself
	assign instr_addr = is_ret              ? ret_top :
	                    (take_jmp | is_cal) ? iaddr_t'(operand) : pc;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= instr_addr + iaddr_t'(1);
		end
	end

	// First word arrives one cycle after reset release
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			instr_valid <= 1'b0;
		end else begin
			instr_valid <= 1'b1;
		end
	end

	// Return stack, PC already points past the CAL
	lifo_stack #(
		.WIDTH (`PROC_IADDR_W),
		.DEPTH (`PROC_RSTACK_DEPTH)
	) i_ret_stack (
		.clk  (clk),
		.rst  (rst),
		.push (is_cal),
		.pop  (is_ret),
		.din  (pc),
		.top  (ret_top)
	);

endmodule

/* hdl/alu.sv */
// Combinational ALU on data words
// Arithmetic wraps, no carry or overflow flags
`timescale 1ns/100ps

module alu
	import proc_pkg::*;
(
	input  alu_op_e    op,
	input  data_word_t a,
	input  data_word_t b,
	output data_word_t y
);

	// a is the accumulator, b the memory word or stack top
	always_comb begin
		case (op)
			ALU_ADD:  y = a + b;
			ALU_AND:  y = a & b;
			ALU_XOR:  y = a ^ b;
			ALU_PASS: y = b;
			default:  y = b;
		endcase
	end

endmodule

/* hdl/lifo_stack.sv */
// Last-in-first-out store with a wrapping pointer
// DEPTH must be a power of two, overflow and underflow are not detected
// Push and pop in the same cycle are not supported
`timescale 1ns/100ps

module lifo_stack #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic             pop,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] top
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam logic [PTR_W-1:0] PTR_ONE = PTR_W'(1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] ptr;
	logic [PTR_W-1:0] ptr_below;

	// Pointer marks the next free slot
	assign ptr_below = ptr - PTR_ONE;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= ptr + PTR_ONE;
		end else if (pop) begin
			ptr <= ptr_below;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[ptr] <= din;
		end
	end

	assign top = mem[ptr_below];

endmodule

/* hdl/proc_pkg.sv */
// Shared types of the stack-accumulator core
// Opcode values come from the macro header, widths likewise

`include "proc_macros.svh"

package proc_pkg;

	// Plain vectors with a meaning
	typedef logic [`PROC_DATA_W-1:0]  data_word_t;
	typedef logic [`PROC_DADDR_W-1:0] daddr_t;
	typedef logic [`PROC_IADDR_W-1:0] iaddr_t;
	typedef logic [`PROC_OPR_W-1:0]   operand_t;
	typedef logic [`PROC_INSTR_W-1:0] instr_word_t;
	typedef logic [`PROC_IO_W-1:0]    io_addr_t;

	typedef enum logic [`PROC_OPC_W-1:0] {
		NOP   = `PROC_OP_NOP,
		LOD   = `PROC_OP_LOD,
		SET   = `PROC_OP_SET,
		PSH   = `PROC_OP_PSH,
		POP   = `PROC_OP_POP,
		ADD   = `PROC_OP_ADD,
		S_ADD = `PROC_OP_S_ADD,
		AND   = `PROC_OP_AND,
		S_AND = `PROC_OP_S_AND,
		XOR   = `PROC_OP_XOR,
		S_XOR = `PROC_OP_S_XOR,
		OUT   = `PROC_OP_OUT,
		JMP   = `PROC_OP_JMP,
		JIZ   = `PROC_OP_JIZ,
		CAL   = `PROC_OP_CAL,
		RET   = `PROC_OP_RET
	} opcode_e;

	typedef enum logic [1:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_AND,
		ALU_XOR
	} alu_op_e;

	// Execute-stage control, one per instruction in flight
	typedef struct packed {
		logic     valid;
		alu_op_e  alu_op;
		logic     use_stack;  // second operand is the stack top, not memory data
		logic     acc_wr;
		logic     push;
		logic     pop;
		logic     mem_wr;
		logic     out_en;
		operand_t operand;
	} exec_ctrl_t;

endpackage

/* hdl/proc_macros.svh */
// Core widths, stack depths and opcode encodings
// Stack depths must be powers of two because the stack pointers wrap
// Opcode values are fixed by the program images and must not be renumbered
`ifndef PROC_MACROS_SVH
`define PROC_MACROS_SVH

// Widths
`define PROC_DATA_W        16
`define PROC_DADDR_W       8
`define PROC_IADDR_W       8
`define PROC_OPC_W         5
`define PROC_OPR_W         8
`define PROC_IO_W          2
`define PROC_INSTR_W       (`PROC_OPC_W + `PROC_OPR_W)

// Stack depths
`define PROC_DSTACK_DEPTH  8
`define PROC_RSTACK_DEPTH  8

// Opcodes
`define PROC_OP_NOP        5'd0
`define PROC_OP_LOD        5'd1
`define PROC_OP_SET        5'd2
`define PROC_OP_PSH        5'd3
`define PROC_OP_POP        5'd4
`define PROC_OP_ADD        5'd5
`define PROC_OP_S_ADD      5'd6
`define PROC_OP_AND        5'd7
`define PROC_OP_S_AND      5'd8
`define PROC_OP_XOR        5'd9
`define PROC_OP_S_XOR      5'd10
`define PROC_OP_OUT        5'd11
`define PROC_OP_JMP        5'd15
`define PROC_OP_JIZ        5'd16
`define PROC_OP_CAL        5'd17
`define PROC_OP_RET        5'd18

`endif
